//--- verilog/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 8;
	localparam int MEM_DEPTH = 256;

	// Memory word
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Address, stride and length all share this width
	typedef logic [ADDR_WIDTH-1:0] address_t;

	// Strided access descriptor, 24 bits
	typedef struct packed {
		address_t base;		// First word
		address_t stride;	// Step between words
		address_t length;	// Word count
	} access_cfg_t;

	// One channel (store or load) of the control block
	typedef enum logic [1:0] {
		CHAN_IDLE,		// Waiting for a grant
		CHAN_START,		// First cycle with the generator loaded
		CHAN_RUN		// Remaining elements
	} chan_state_t;

endpackage

`default_nettype wire

//--- verilog/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
	input logic clock,
	input logic reset,
	input logic req_1,
	input logic req_2,
	input dmem_pkg::access_cfg_t cfg_1,
	input dmem_pkg::access_cfg_t cfg_2,
	input logic release_grant,
	output logic grant_1,
	output logic grant_2,
	output dmem_pkg::access_cfg_t cfg,
	output logic granted,
	output logic grant_no
);

	logic busy;
	logic last;			// Last served port, also the current grant index
	logic winner;
	dmem_pkg::access_cfg_t cfg_q;

	// Both asking: take the one not served last
	assign winner = (req_1 && req_2) ? ~last : req_2;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			last <= 1'b1;		// So port 1 wins first
		end
		else if (release_grant) begin
			busy <= 1'b0;
		end
		else if (!busy && (req_1 || req_2)) begin
			busy <= 1'b1;
			last <= winner;
		end
	end

	// Descriptor capture
	always_ff @(posedge clock) begin
		if (!busy && (req_1 || req_2)) begin
			cfg_q <= winner ? cfg_2 : cfg_1;
		end
	end

	assign grant_1 = busy & ~last;
	assign grant_2 = busy & last;
	assign granted = busy;
	assign grant_no = last;
	assign cfg = cfg_q;

endmodule

`default_nettype wire

//--- verilog/stride_agu.sv
`timescale 1ns/1ps
`default_nettype none

module stride_agu (
	input logic clock,
	input logic reset,
	input logic start,
	input logic step,
	input dmem_pkg::access_cfg_t cfg,
	output dmem_pkg::address_t address,
	output logic active,
	output logic last_done
);

	dmem_pkg::address_t address_q;
	dmem_pkg::address_t stride_q;
	dmem_pkg::address_t remaining;

	always_ff @(posedge clock) begin
		if (reset) begin
			remaining <= '0;
		end
		else if (start) begin
			remaining <= cfg.length;
		end
		else if (step && active) begin
			remaining <= remaining - 1'b1;
		end
	end

	// Wraps modulo the memory depth
	always_ff @(posedge clock) begin
		if (start) begin
			address_q <= cfg.base;
			stride_q <= cfg.stride;
		end
		else if (step && active) begin
			address_q <= address_q + stride_q;
		end
	end

	assign active = (remaining != '0);

	// Zero length finishes in the start cycle
	assign last_done = (start && (cfg.length == '0))
		|| (step && (remaining == dmem_pkg::address_t'(1)));

	assign address = address_q;

endmodule

`default_nettype wire

//--- verilog/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input logic clock,
	input logic write_enable,
	input dmem_pkg::address_t write_address,
	input dmem_pkg::data_t write_data,
	input logic read_enable,
	input dmem_pkg::address_t read_address,
	output dmem_pkg::data_t read_data
);

	dmem_pkg::data_t mem [0:dmem_pkg::MEM_DEPTH-1];
	dmem_pkg::data_t read_q;

	always_ff @(posedge clock) begin
		if (write_enable) begin
			mem[write_address] <= write_data;
		end
	end

	// Same-address write in this cycle returns the old word
	always_ff @(posedge clock) begin
		if (read_enable) begin
			read_q <= mem[read_address];
		end
	end

	assign read_data = read_q;

endmodule

`default_nettype wire

//--- verilog/dmem_control.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_control (
	input logic clock,
	input logic reset,
	input logic st_granted,
	input logic st_grant_no,
	input logic ld_granted,
	input logic ld_grant_no,
	input logic st_valid_1,
	input logic st_valid_2,
	input logic ld_valid_1,
	input logic ld_valid_2,
	input dmem_pkg::data_t st_data_1,
	input dmem_pkg::data_t st_data_2,
	input logic st_active,
	input logic st_end,
	input logic ld_active,
	input logic ld_end,
	input dmem_pkg::data_t read_data,
	output logic st_start,
	output logic st_step,
	output logic ld_start,
	output logic ld_step,
	output logic st_release,
	output logic ld_release,
	output dmem_pkg::data_t write_data,
	output logic st_ready_1,
	output logic st_ready_2,
	output dmem_pkg::data_t ld_data_1,
	output dmem_pkg::data_t ld_data_2,
	output logic ld_ready_1,
	output logic ld_ready_2
);

	dmem_pkg::chan_state_t st_state;
	dmem_pkg::chan_state_t ld_state;
	logic st_valid;
	logic ld_valid;
	logic ld_strobe;	// Read issued last cycle
	logic ld_owner;		// Port that issued it

	function automatic dmem_pkg::chan_state_t chan_next(
		input dmem_pkg::chan_state_t state,
		input logic granted,
		input logic done
	);
		dmem_pkg::chan_state_t state_next;
		state_next = state;
		case (state)
			dmem_pkg::CHAN_IDLE: begin
				if (granted && !done) begin
					state_next = dmem_pkg::CHAN_START;
				end
			end
			dmem_pkg::CHAN_START: begin
				state_next = done ? dmem_pkg::CHAN_IDLE : dmem_pkg::CHAN_RUN;
			end
			dmem_pkg::CHAN_RUN: begin
				if (done) begin
					state_next = dmem_pkg::CHAN_IDLE;
				end
			end
			default: begin
				state_next = dmem_pkg::CHAN_IDLE;
			end
		endcase
		return state_next;
	endfunction

	// Valid of the granted requester
	assign st_valid = st_grant_no ? st_valid_2 : st_valid_1;
	assign ld_valid = ld_grant_no ? ld_valid_2 : ld_valid_1;

	// Start in the first granted cycle
	assign st_start = st_granted && (st_state == dmem_pkg::CHAN_IDLE);
	assign ld_start = ld_granted && (ld_state == dmem_pkg::CHAN_IDLE);

	assign st_step = st_active && st_valid && (st_state != dmem_pkg::CHAN_IDLE);
	assign ld_step = ld_active && ld_valid && (ld_state != dmem_pkg::CHAN_IDLE);

	assign st_release = st_end;
	assign ld_release = ld_end;

	always_ff @(posedge clock) begin
		if (reset) begin
			st_state <= dmem_pkg::CHAN_IDLE;
			ld_state <= dmem_pkg::CHAN_IDLE;
			ld_strobe <= 1'b0;
			ld_owner <= 1'b0;
		end
		else begin
			st_state <= chan_next(st_state, st_granted, st_end);
			ld_state <= chan_next(ld_state, ld_granted, ld_end);
			ld_strobe <= ld_step;
			if (ld_step) begin
				ld_owner <= ld_grant_no;
			end
		end
	end

	assign write_data = st_grant_no ? st_data_2 : st_data_1;
	assign st_ready_1 = st_active && !st_grant_no;
	assign st_ready_2 = st_active && st_grant_no;

	// Grant may already be gone after the last read
	assign ld_ready_1 = ld_strobe && !ld_owner;
	assign ld_ready_2 = ld_strobe && ld_owner;
	assign ld_data_1 = ld_ready_1 ? read_data : '0;
	assign ld_data_2 = ld_ready_2 ? read_data : '0;

endmodule

`default_nettype wire

//--- verilog/dmem_top.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_top (
	input logic clock,
	input logic reset,
	input logic st_req_1,
	input logic st_req_2,
	input dmem_pkg::access_cfg_t st_cfg_1,
	input dmem_pkg::access_cfg_t st_cfg_2,
	input logic st_valid_1,
	input logic st_valid_2,
	input dmem_pkg::data_t st_data_1,
	input dmem_pkg::data_t st_data_2,
	output logic st_grant_1,
	output logic st_grant_2,
	output logic st_ready_1,
	output logic st_ready_2,
	input logic ld_req_1,
	input logic ld_req_2,
	input dmem_pkg::access_cfg_t ld_cfg_1,
	input dmem_pkg::access_cfg_t ld_cfg_2,
	input logic ld_valid_1,
	input logic ld_valid_2,
	output logic ld_grant_1,
	output logic ld_grant_2,
	output logic ld_ready_1,
	output logic ld_ready_2,
	output dmem_pkg::data_t ld_data_1,
	output dmem_pkg::data_t ld_data_2
);

	dmem_pkg::access_cfg_t st_cfg;
	dmem_pkg::access_cfg_t ld_cfg;
	dmem_pkg::address_t st_address;
	dmem_pkg::address_t ld_address;
	dmem_pkg::data_t write_data;
	dmem_pkg::data_t read_data;
	logic st_granted;
	logic st_grant_no;
	logic st_active;
	logic st_end;
	logic st_start;
	logic st_step;
	logic st_release;
	logic ld_granted;
	logic ld_grant_no;
	logic ld_active;
	logic ld_end;
	logic ld_start;
	logic ld_step;
	logic ld_release;

	req_arbiter st_arbiter (
		.clock			(clock),
		.reset			(reset),
		.req_1			(st_req_1),
		.req_2			(st_req_2),
		.cfg_1			(st_cfg_1),
		.cfg_2			(st_cfg_2),
		.release_grant	(st_release),
		.grant_1		(st_grant_1),
		.grant_2		(st_grant_2),
		.cfg			(st_cfg),
		.granted		(st_granted),
		.grant_no		(st_grant_no)
	);

	req_arbiter ld_arbiter (
		.clock			(clock),
		.reset			(reset),
		.req_1			(ld_req_1),
		.req_2			(ld_req_2),
		.cfg_1			(ld_cfg_1),
		.cfg_2			(ld_cfg_2),
		.release_grant	(ld_release),
		.grant_1		(ld_grant_1),
		.grant_2		(ld_grant_2),
		.cfg			(ld_cfg),
		.granted		(ld_granted),
		.grant_no		(ld_grant_no)
	);

	stride_agu st_agu (
		.clock		(clock),
		.reset		(reset),
		.start		(st_start),
		.step		(st_step),
		.cfg		(st_cfg),
		.address	(st_address),
		.active		(st_active),
		.last_done	(st_end)
	);

	stride_agu ld_agu (
		.clock		(clock),
		.reset		(reset),
		.start		(ld_start),
		.step		(ld_step),
		.cfg		(ld_cfg),
		.address	(ld_address),
		.active		(ld_active),
		.last_done	(ld_end)
	);

	dmem_control control (
		.clock			(clock),
		.reset			(reset),
		.st_granted		(st_granted),
		.st_grant_no	(st_grant_no),
		.ld_granted		(ld_granted),
		.ld_grant_no	(ld_grant_no),
		.st_valid_1		(st_valid_1),
		.st_valid_2		(st_valid_2),
		.ld_valid_1		(ld_valid_1),
		.ld_valid_2		(ld_valid_2),
		.st_data_1		(st_data_1),
		.st_data_2		(st_data_2),
		.st_active		(st_active),
		.st_end			(st_end),
		.ld_active		(ld_active),
		.ld_end			(ld_end),
		.read_data		(read_data),
		.st_start		(st_start),
		.st_step		(st_step),
		.ld_start		(ld_start),
		.ld_step		(ld_step),
		.st_release		(st_release),
		.ld_release		(ld_release),
		.write_data		(write_data),
		.st_ready_1		(st_ready_1),
		.st_ready_2		(st_ready_2),
		.ld_data_1		(ld_data_1),
		.ld_data_2		(ld_data_2),
		.ld_ready_1		(ld_ready_1),
		.ld_ready_2		(ld_ready_2)
	);

	// Store steps write, load steps read
	data_mem memory (
		.clock			(clock),
		.write_enable	(st_step),
		.write_address	(st_address),
		.write_data		(write_data),
		.read_enable	(ld_step),
		.read_address	(ld_address),
		.read_data		(read_data)
	);

endmodule

`default_nettype wire

//--- bench/dmem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_properties (
	input logic clock,
	input logic reset,
	input logic st_grant_1,
	input logic st_grant_2,
	input logic st_ready_1,
	input logic st_ready_2,
	input logic ld_grant_1,
	input logic ld_grant_2,
	input logic ld_valid_1,
	input logic ld_valid_2,
	input logic ld_ready_1,
	input logic ld_ready_2
);

	int failures = 0;	// Failed assertion count

	// One owner per direction
	assert property (@(posedge clock) disable iff (reset)
		!(st_grant_1 && st_grant_2) && !(ld_grant_1 && ld_grant_2))
		else begin
			failures++;
			$error("Two grants in one direction");
		end

	assert property (@(posedge clock) disable iff (reset)
		!(st_ready_1 && !st_grant_1) && !(st_ready_2 && !st_grant_2))
		else begin
			failures++;
			$error("Store ready without its grant");
		end

	// Read data one cycle after the step
	assert property (@(posedge clock) disable iff (reset)
		ld_ready_1 |-> $past(ld_grant_1 && ld_valid_1))
		else begin
			failures++;
			$error("Load ready 1 without a granted valid");
		end

	assert property (@(posedge clock) disable iff (reset)
		ld_ready_2 |-> $past(ld_grant_2 && ld_valid_2))
		else begin
			failures++;
			$error("Load ready 2 without a granted valid");
		end

endmodule

bind dmem_top dmem_properties props (.*);

`default_nettype wire

//--- bench/dmem_bench.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_bench;

	logic clock = 1'b0;
	logic reset;
	logic st_req [1:2];
	logic st_valid [1:2];
	logic st_grant [1:2];
	logic st_ready [1:2];
	dmem_pkg::access_cfg_t st_cfg [1:2];
	dmem_pkg::data_t st_data [1:2];
	logic ld_req [1:2];
	logic ld_valid [1:2];
	logic ld_grant [1:2];
	logic ld_ready [1:2];
	dmem_pkg::access_cfg_t ld_cfg [1:2];
	dmem_pkg::data_t ld_data [1:2];
	dmem_pkg::data_t ref_mem [0:dmem_pkg::MEM_DEPTH-1];	// Words stored so far
	int grant_order [$];	// Store ports in grant order
	logic [31:0] lcg_state = 32'ha39a;
	int errors = 0;
	int cycles = 0;

	dmem_top UUT (
		.clock		(clock),
		.reset		(reset),
		.st_req_1	(st_req[1]),
		.st_req_2	(st_req[2]),
		.st_cfg_1	(st_cfg[1]),
		.st_cfg_2	(st_cfg[2]),
		.st_valid_1	(st_valid[1]),
		.st_valid_2	(st_valid[2]),
		.st_data_1	(st_data[1]),
		.st_data_2	(st_data[2]),
		.st_grant_1	(st_grant[1]),
		.st_grant_2	(st_grant[2]),
		.st_ready_1	(st_ready[1]),
		.st_ready_2	(st_ready[2]),
		.ld_req_1	(ld_req[1]),
		.ld_req_2	(ld_req[2]),
		.ld_cfg_1	(ld_cfg[1]),
		.ld_cfg_2	(ld_cfg[2]),
		.ld_valid_1	(ld_valid[1]),
		.ld_valid_2	(ld_valid[2]),
		.ld_grant_1	(ld_grant[1]),
		.ld_grant_2	(ld_grant[2]),
		.ld_ready_1	(ld_ready[1]),
		.ld_ready_2	(ld_ready[2]),
		.ld_data_1	(ld_data[1]),
		.ld_data_2	(ld_data[2])
	);

	always #2 clock = ~clock;

	// About 110 words at half throughput, so a few hundred cycles
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == 4000) begin
			$display("Timeout after %0d cycles with %0d errors", cycles, errors);
			$display("Something failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic run_store(input int port, input dmem_pkg::access_cfg_t cfg);
		dmem_pkg::address_t address;
		dmem_pkg::address_t count;
		address = cfg.base;
		count = '0;
		st_cfg[port] = cfg;
		st_req[port] = 1'b1;
		while (!st_grant[port]) begin
			@(negedge clock);
		end
		grant_order.push_back(port);
		st_req[port] = 1'b0;
		@(negedge clock);
		while (count != cfg.length) begin
			if (st_ready[port]) begin
				lcg_state = lcg_next(lcg_state);
				st_valid[port] = lcg_state[27];	// Random gaps
				st_data[port] = lcg_next(lcg_state);
				if (st_valid[port]) begin
					ref_mem[address] = st_data[port];
					address = address + cfg.stride;	// Wraps at the depth
					count = count + dmem_pkg::address_t'(1);
				end
			end
			else begin
				st_valid[port] = 1'b0;
			end
			@(negedge clock);
		end
		st_valid[port] = 1'b0;
		assert (!st_grant[port] && !st_ready[port]) else begin
			errors++;
			$display("Store port %0d still granted after %0d words", port, cfg.length);
		end
	endtask

	task automatic run_load(input int port, input dmem_pkg::access_cfg_t cfg);
		dmem_pkg::address_t address;
		dmem_pkg::address_t count;
		address = cfg.base;
		count = '0;
		ld_cfg[port] = cfg;
		ld_req[port] = 1'b1;
		while (!ld_grant[port]) begin
			@(negedge clock);
		end
		ld_req[port] = 1'b0;
		@(negedge clock);
		while (count != cfg.length) begin
			lcg_state = lcg_next(lcg_state);
			ld_valid[port] = ld_grant[port] && lcg_state[27];
			@(negedge clock);
			if (ld_ready[port]) begin
				assert (ld_data[port] == ref_mem[address]) else begin
					errors++;
					$display("MISMATCH at %0t: ld_data_%0d = %h, expected %h",
						$time, port, ld_data[port], ref_mem[address]);
				end
				address = address + cfg.stride;
				count = count + dmem_pkg::address_t'(1);
			end
		end
		ld_valid[port] = 1'b0;
		@(negedge clock);
		assert (!ld_grant[port] && !ld_ready[port]) else begin
			errors++;
			$display("Load port %0d returned more than %0d words", port, cfg.length);
		end
	endtask

	task automatic check_idle();
		for (int i = 1; i <= 2; i++) begin
			assert (!st_grant[i] && !st_ready[i] && !ld_grant[i] && !ld_ready[i]) else begin
				errors++;
				$display("Port %0d has a grant or ready high after reset", i);
			end
			assert (ld_data[i] == '0) else begin
				errors++;
				$display("MISMATCH at %0t: ld_data_%0d = %h, expected 0", $time, i, ld_data[i]);
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		for (int i = 1; i <= 2; i++) begin
			st_req[i] = 1'b0;
			st_valid[i] = 1'b0;
			st_cfg[i] = '0;
			st_data[i] = '0;
			ld_req[i] = 1'b0;
			ld_valid[i] = 1'b0;
			ld_cfg[i] = '0;
		end
		repeat (2) @(negedge clock);
		reset = 1'b0;
		check_idle();
		// Both store ports back to back, round robin from port 1
		grant_order.delete();
		fork
			begin
				run_store(1, '{base: 8'h40, stride: 8'd1, length: 8'd5});
				run_store(1, '{base: 8'h40, stride: 8'd1, length: 8'd5});
			end
			begin
				run_store(2, '{base: 8'h60, stride: 8'd2, length: 8'd5});
				run_store(2, '{base: 8'h60, stride: 8'd2, length: 8'd5});
			end
		join
		foreach (grant_order[i]) begin
			assert (grant_order[i] == (i % 2) + 1) else begin
				errors++;
				$display("MISMATCH at %0t: store grant order[%0d] = %0d, expected %0d",
					$time, i, grant_order[i], (i % 2) + 1);
			end
		end
		fork
			run_load(1, '{base: 8'h40, stride: 8'd1, length: 8'd5});
			run_load(2, '{base: 8'h60, stride: 8'd2, length: 8'd5});
		join
		run_store(1, '{base: 8'h10, stride: 8'd3, length: 8'd12});
		run_load(2, '{base: 8'h10, stride: 8'd3, length: 8'd12});
		// Stride 37 runs past the top several times
		run_store(2, '{base: 8'hf0, stride: 8'd37, length: 8'd20});
		run_load(1, '{base: 8'hf0, stride: 8'd37, length: 8'd20});
		run_store(1, '{base: 8'h10, stride: 8'd3, length: 8'd0});
		run_load(1, '{base: 8'h10, stride: 8'd3, length: 8'd0});
		run_load(2, '{base: 8'h10, stride: 8'd3, length: 8'd12});
		$display("Errors: %0d in the bench, %0d in assertions", errors, UUT.props.failures);
		if (errors == 0 && UUT.props.failures == 0) begin
			$display("Everything OK");
		end
		else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/dmem_pkg.sv
verilog/req_arbiter.sv
verilog/stride_agu.sv
verilog/data_mem.sv
verilog/dmem_control.sv
verilog/dmem_top.sv
bench/dmem_properties.sv
bench/dmem_bench.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module dmem_bench -f list.f

output=$(./obj_dir/Vdmem_bench +verilator+error+limit+100 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
